// File: source/mem_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction memory shared types
// word, address and sequencer types plus
// the start-up image copied into ram
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_pkg;

    typedef logic [15:0] word_t;     // one 16-bit instruction or data word
    typedef logic [14:0] addr_t;     // word address, 32K words reachable
    typedef logic [3:0]  init_idx_t; // walks the start-up image

    // start-up sequencer
    typedef enum logic
    {
        INIT_WRITE, // copying the image into ram
        READY       // serving the bus
    } init_state_t;

    localparam int BOOT_WORDS = 16; // size of the bootloader rom window

    // written into ram words 0..15 after reset
    // a cpu starting at 0 reads the boot base first and ends up in the rom
    localparam word_t init_image [2**$bits(init_idx_t)] = '{
        16'h7ff0, // boot base, default RAM_DEPTH
        16'h0010, // set 0
        16'h00f0, // load WR
        16'h0008, // jmp
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000,
        16'h0000
    };

endpackage

// File: source/ram16.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port instruction ram
// registered read, output zero when idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ram16 #(
    parameter int RAM_DEPTH = 32752
)(
    input  logic           clk,
    input  logic           en,
    input  logic           write_en,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::word_t wdata,
    output mem_pkg::word_t rdata
);
    import mem_pkg::*;

    word_t mem [RAM_DEPTH]; // contents only fixed by the start-up image

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (write_en)
                mem[addr] <= wdata;
            rdata <= mem[addr]; // old word on a write
        end
        else
        begin
            rdata <= '0; // lets the rom output be ored in
        end
    end

endmodule

// File: source/boot_rom16.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bootloader rom, 16 words
// filled from the boot hex image
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module boot_rom16 (
    input  logic           clk,
    input  logic           en,
    input  mem_pkg::addr_t addr,
    output mem_pkg::word_t rdata
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(BOOT_WORDS);

    word_t rom [BOOT_WORDS];

    initial
    begin
        $readmemh("boot16.hex", rom); // bootloader code
    end

    always_ff @(posedge clk)
    begin
        if (en)
            rdata <= rom[addr[IDX_W-1:0]]; // window offset only
        else
            rdata <= '0; // zero when not selected
    end

endmodule

// File: source/bus_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request decode stage
// buffers host requests, returns credits,
// splits ram / rom and drops rom writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bus_decode #(
    parameter int RAM_DEPTH = 32752,
    parameter int REQ_DEPTH = 4
)(
    input  logic           clk,
    input  logic           reset,
    // host request channel
    input  logic           req_valid,
    input  mem_pkg::addr_t req_addr,
    input  mem_pkg::word_t req_wdata,
    input  logic           req_write,
    output logic           req_credit,
    // execute stage handshake
    input  logic           inst_ready,
    input  logic           slot_free,
    output logic           issue,
    output logic           issue_write,
    output logic           ram_sel,
    output logic           rom_sel,
    output mem_pkg::addr_t issue_addr,
    output mem_pkg::word_t issue_wdata
);
    import mem_pkg::*;

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);
    localparam addr_t ROM_BASE = addr_t'(RAM_DEPTH); // first rom word

    // request payload
    addr_t fifo_addr  [REQ_DEPTH];
    word_t fifo_wdata [REQ_DEPTH];
    logic  fifo_write [REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             full;
    logic             head_rom;
    logic             discard;
    logic             pop;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(REQ_DEPTH));
    assign head_rom = (fifo_addr[rd_ptr] >= ROM_BASE); // above ram -> boot rom

    // rom writes leave the fifo without touching memory
    assign discard = !empty && fifo_write[rd_ptr] && head_rom;
    // reads need a response slot, writes only need the memory
    assign issue   = !empty && inst_ready && !discard && (fifo_write[rd_ptr] || slot_free);
    assign pop     = issue || discard;

    assign issue_addr  = fifo_addr[rd_ptr];
    assign issue_wdata = fifo_wdata[rd_ptr];
    assign issue_write = fifo_write[rd_ptr];
    assign ram_sel     = !head_rom;
    assign rom_sel     = head_rom;

    always_ff @(posedge clk)
    begin
        if (req_valid) // host only sends on a credit
        begin
            fifo_addr[wr_ptr]  <= req_addr;
            fifo_wdata[wr_ptr] <= req_wdata;
            fifo_write[wr_ptr] <= req_write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end
        else
        begin
            if (req_valid)
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none or both
            endcase
            req_credit <= pop; // one credit back per entry gone
        end
    end

    // host credits must keep the fifo from overrunning
    a_req_no_overrun: assert property (@(posedge clk) disable iff (!reset)
        req_valid |-> !full)
        else $error("request arrived while the request fifo was full");

endmodule

// File: source/inst_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage, instruction memory
// copies the start-up image into ram,
// then serves issued ram and rom accesses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module inst_mem #(
    parameter int RAM_DEPTH = 32752
)(
    input  logic           clk,
    input  logic           reset,
    input  logic           issue,
    input  logic           issue_write,
    input  logic           ram_sel,
    input  logic           rom_sel,
    input  mem_pkg::addr_t issue_addr,
    input  mem_pkg::word_t issue_wdata,
    output logic           inst_ready,
    output logic           rd_valid,
    output mem_pkg::word_t rd_data
);
    import mem_pkg::*;

    init_state_t state;
    init_idx_t   init_idx; // image word being written

    // muxed memory inputs
    addr_t mem_addr;
    word_t mem_wdata;
    logic  ram_en;
    logic  ram_we;
    logic  rom_en;
    word_t ram_rdata;
    word_t rom_rdata;

    // start-up sequencer, one image word per cycle
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state    <= INIT_WRITE;
            init_idx <= '0;
        end
        else
        begin
            case (state)
                INIT_WRITE:
                begin
                    if (init_idx == init_idx_t'($size(init_image) - 1))
                        state <= READY; // last word goes in this cycle
                    else
                        init_idx <= init_idx + 1'b1;
                end
                default: state <= READY; // stays here until reset
            endcase
        end
    end

    assign inst_ready = (state == READY);

    // sequencer owns the ram port until the image is in
    always_comb
    begin
        if (state == INIT_WRITE)
        begin
            mem_addr  = addr_t'(init_idx);
            mem_wdata = init_image[init_idx];
            ram_en    = 1'b1;
            ram_we    = 1'b1;
            rom_en    = 1'b0;
        end
        else
        begin
            mem_addr  = issue_addr;
            mem_wdata = issue_wdata;
            ram_en    = issue && ram_sel;
            ram_we    = issue_write;
            rom_en    = issue && rom_sel && !issue_write; // rom is read only
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            rd_valid <= 1'b0;
        else
            rd_valid <= issue && !issue_write; // data lands next cycle
    end

    assign rd_data = ram_rdata | rom_rdata; // idle memory drives zero

    ram16 #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
        .clk      (clk),
        .en       (ram_en),
        .write_en (ram_we),
        .addr     (mem_addr),
        .wdata    (mem_wdata),
        .rdata    (ram_rdata)
    );

    boot_rom16 u_rom (
        .clk   (clk),
        .en    (rom_en),
        .addr  (mem_addr),
        .rdata (rom_rdata)
    );

    // decode must hold off until the image is written
    a_no_issue_in_init: assert property (@(posedge clk) disable iff (!reset)
        issue |-> (state == READY))
        else $error("access issued during start-up image write");

endmodule

// File: source/rsp_return.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response return stage
// holds read data in order and sends it
// back as host response credits allow
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rsp_return #(
    parameter int RSP_DEPTH = 4
)(
    input  logic           clk,
    input  logic           reset,
    input  logic           reserve,    // read issued, claims a slot
    input  logic           rd_valid,
    input  mem_pkg::word_t rd_data,
    output logic           slot_free,
    input  logic           rsp_credit, // one credit per pulse
    output logic           rsp_valid,
    output mem_pkg::word_t rsp_data
);
    import mem_pkg::*;

    localparam int PTR_W  = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_W  = $clog2(RSP_DEPTH + 1);
    localparam int CRED_W = 16; // host may bank many credits

    word_t fifo [RSP_DEPTH]; // read data in arrival order

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  data_cnt; // words waiting
    logic [CNT_W-1:0]  resv_cnt; // in flight plus waiting
    logic [CRED_W-1:0] credits;
    logic              send;

    assign send      = (data_cnt != '0) && (credits != '0);
    assign rsp_valid = send;
    assign rsp_data  = fifo[rd_ptr];
    assign slot_free = (resv_cnt < CNT_W'(RSP_DEPTH));

    always_ff @(posedge clk)
    begin
        if (rd_valid)
            fifo[wr_ptr] <= rd_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            data_cnt <= '0;
            resv_cnt <= '0;
            credits  <= '0; // host grants before the first response
        end
        else
        begin
            if (rd_valid)
                wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (send)
                rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({rd_valid, send})
                2'b10:   data_cnt <= data_cnt + 1'b1;
                2'b01:   data_cnt <= data_cnt - 1'b1;
                default: data_cnt <= data_cnt;
            endcase
            case ({reserve, send}) // slot freed only once sent
                2'b10:   resv_cnt <= resv_cnt + 1'b1;
                2'b01:   resv_cnt <= resv_cnt - 1'b1;
                default: resv_cnt <= resv_cnt;
            endcase
            case ({rsp_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // a grant on a full counter would wrap and lose banked credits
    a_rsp_credit_no_wrap: assert property (@(posedge clk) disable iff (!reset)
        (rsp_credit && !send) |-> (credits != '1))
        else $error("response credit counter overflowed");

    // every read result must have been reserved at issue
    a_rd_in_reserved: assert property (@(posedge clk) disable iff (!reset)
        rd_valid |-> (data_cnt < resv_cnt))
        else $error("read data arrived without a reserved slot");

endmodule

// File: source/inst_mem_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction memory subsystem top
// decode, memory and response stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module inst_mem_top #(
    parameter int RAM_DEPTH = 32752, // rom window starts here
    parameter int REQ_DEPTH = 4,     // also the host's starting credits
    parameter int RSP_DEPTH = 4
)(
    input  logic           clk,
    input  logic           reset,
    input  logic           req_valid,
    input  logic           req_write,
    input  mem_pkg::addr_t req_addr,
    input  mem_pkg::word_t req_wdata,
    output logic           req_credit,
    output mem_pkg::word_t rsp_data,
    output logic           rsp_valid,
    input  logic           rsp_credit,
    output logic           inst_ready
);
    import mem_pkg::*;

    logic  issue;
    logic  issue_write;
    logic  ram_sel;
    logic  rom_sel;
    addr_t issue_addr;
    word_t issue_wdata;
    logic  slot_free;
    logic  rd_valid;
    word_t rd_data;
    wire   issue_read = issue & ~issue_write; // slot claim pulse

    bus_decode #(.RAM_DEPTH(RAM_DEPTH), .REQ_DEPTH(REQ_DEPTH)) u_decode (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_write   (req_write),
        .req_credit  (req_credit),
        .inst_ready  (inst_ready),
        .slot_free   (slot_free),
        .issue       (issue),
        .issue_write (issue_write),
        .ram_sel     (ram_sel),
        .rom_sel     (rom_sel),
        .issue_addr  (issue_addr),
        .issue_wdata (issue_wdata)
    );

    inst_mem #(.RAM_DEPTH(RAM_DEPTH)) u_mem (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .issue_write (issue_write),
        .ram_sel     (ram_sel),
        .rom_sel     (rom_sel),
        .issue_addr  (issue_addr),
        .issue_wdata (issue_wdata),
        .inst_ready  (inst_ready),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    rsp_return #(.RSP_DEPTH(RSP_DEPTH)) u_rsp (
        .clk        (clk),
        .reset      (reset),
        .reserve    (issue_read),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .slot_free  (slot_free),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data)
    );

endmodule

// File: dv/tb_inst_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction memory subsystem testbench
// credit-driven random traffic checked
// against a word-array reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_inst_mem;
    import mem_pkg::*;

    localparam int RAM_DEPTH    = 32752;
    localparam int REQ_DEPTH    = 4;
    localparam int N_RANDOM     = 300;
    localparam int READY_LIMIT  = 20;   // image copy takes 16
    localparam int WAIT_LIMIT   = 2000; // cycles per wait loop
    localparam int GRANT_NONE   = 0;
    localparam int GRANT_ALL    = 1;
    localparam int GRANT_RANDOM = 2;

    logic  clk = 1'b0;
    logic  reset;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    logic  req_credit;
    word_t rsp_data;
    logic  rsp_valid;
    logic  rsp_credit;
    logic  inst_ready;

    word_t model [32768];   // whole address space, rom on top
    bit    known [32768];   // word holds a defined value
    word_t exp_q [$];       // expected read data in request order
    addr_t exp_addr_q [$];
    logic [31:0] rng;
    int host_credits;
    int rsp_bank;           // granted minus used, never below the dut's
    int sent_count;
    int read_count;
    int credit_pulses;
    int rsp_count;
    int checks;
    int errors;
    int test_num;
    int test_errors;
    bit test_skipped;
    bit aborted;            // a wait timed out
    int grant_mode;

    inst_mem_top UUT (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_credit (req_credit),
        .rsp_data   (rsp_data),
        .rsp_valid  (rsp_valid),
        .rsp_credit (rsp_credit),
        .inst_ready (inst_ready)
    );

    initial
    begin
        forever #50 clk = ~clk; // 100 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // half low ram, a quarter rom window, a quarter anywhere in ram
    function automatic addr_t pick_addr(input logic [31:0] r);
        case (r[1:0])
            2'b00, 2'b01: return addr_t'(r[21:16]);
            2'b10:        return addr_t'(RAM_DEPTH + int'(r[7:4]));
            default:      return addr_t'(int'(r[30:16]) % RAM_DEPTH);
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t want, input string what);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        checks++;
        if (got != want)
        begin
            errors++;
            $display("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, want);
        end
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        aborted = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // one host cycle, the model follows every request as it is sent
    task automatic drive_cycle(input logic send, input logic wr, input addr_t a, input word_t d);
        logic [31:0] r;
        logic        grant;
        r = next_random();
        case (grant_mode)
            GRANT_ALL:    grant = 1'b1;
            GRANT_RANDOM: grant = r[9];
            default:      grant = 1'b0;
        endcase
        @(posedge clk);
        req_valid  <= send;
        req_write  <= wr;
        req_addr   <= a;
        req_wdata  <= d;
        rsp_credit <= grant;
        if (grant)
            rsp_bank++;
        if (send)
        begin
            host_credits--;
            sent_count++;
            if (!wr)
            begin
                read_count++;
                exp_q.push_back(model[a]);
                exp_addr_q.push_back(a);
            end
            else if (int'(a) < RAM_DEPTH) // rom writes vanish
            begin
                model[a] = d;
                known[a] = 1'b1;
            end
        end
    endtask

    task automatic send_req(input logic wr, input addr_t a, input word_t d);
        int waited;
        if (!aborted)
        begin
            waited = 0;
            while (host_credits == 0 && waited < WAIT_LIMIT)
            begin
                drive_cycle(1'b0, 1'b0, '0, '0);
                waited++;
            end
            if (host_credits == 0)
                timeout_fail("request credit never came back");
            else
                drive_cycle(1'b1, wr, a, d);
        end
    endtask

    // idle until every read is answered and every credit is home
    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || host_credits != REQ_DEPTH) && waited < WAIT_LIMIT)
        begin
            drive_cycle(1'b0, 1'b0, '0, '0);
            waited++;
        end
        if (exp_q.size() != 0)
            timeout_fail("response never arrived");
        else if (host_credits != REQ_DEPTH)
            timeout_fail("request credits never all came back");
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (inst_ready !== 1'b1 && waited < READY_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (inst_ready !== 1'b1)
            timeout_fail("ready never rose");
    endtask

    task automatic start_test();
        test_num++;
        test_errors  = errors;
        test_skipped = aborted;
    endtask

    task automatic end_test(input string name);
        if (test_skipped)
            $display("test %0d %s: not run", test_num, name);
        else if (errors == test_errors)
            $display("test %0d %s: pass", test_num, name);
        else
            $display("test %0d %s: FAIL with %0d errors", test_num, name, errors - test_errors);
    endtask

    // host side of both credit channels, outputs are stable at the falling edge
    always @(negedge clk)
    begin : monitor
        word_t want;
        addr_t a;
        if (reset === 1'b1)
        begin
            if (req_credit === 1'b1)
            begin
                credit_pulses++;
                host_credits++;
                if (host_credits > REQ_DEPTH)
                begin
                    errors++;
                    $display("at %0t more request credits came back than were spent", $time);
                end
            end
            if (rsp_valid === 1'b1)
            begin
                rsp_count++;
                if (rsp_bank > 0)
                    rsp_bank--;
                else
                begin
                    errors++;
                    $display("at %0t a response was sent without a response credit", $time);
                end
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("at %0t a response arrived with no read outstanding", $time);
                end
                else
                begin
                    want = exp_q.pop_front();
                    a    = exp_addr_q.pop_front();
                    check_word(rsp_data, want, $sformatf("read of %h", a));
                end
            end
        end
    end

    initial
    begin
        addr_t       a;
        logic [31:0] r;
        int          i;
        int          bank_start;
        int          rsp_start;
        reset         = 1'b0;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_wdata     = '0;
        rsp_credit    = 1'b0;
        rng           = 32'hdf4b82f5;
        host_credits  = REQ_DEPTH;
        rsp_bank      = 0;
        sent_count    = 0;
        read_count    = 0;
        credit_pulses = 0;
        rsp_count     = 0;
        checks        = 0;
        errors        = 0;
        test_num      = 0;
        aborted       = 1'b0;
        grant_mode    = GRANT_NONE;

        // start-up image: boot base, set, load, jump, then zeros
        model[0] = 16'h7ff0;
        model[1] = 16'h0010;
        model[2] = 16'h00f0;
        model[3] = 16'h0008;
        for (i = 4; i < 16; i++)
            model[i] = '0;
        $readmemh("boot16.hex", model, RAM_DEPTH);
        for (i = 0; i < 16; i++)
        begin
            known[i]             = 1'b1;
            known[RAM_DEPTH + i] = 1'b1;
        end

        repeat (3) @(posedge clk);
        reset <= 1'b1;

        start_test();
        @(negedge clk);
        check_flag(req_credit, 1'b0, "req_credit after reset");
        check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
        check_flag(inst_ready, 1'b0, "inst_ready during image copy");
        wait_ready();
        end_test("reset and image copy");

        start_test();
        grant_mode = GRANT_ALL;
        for (i = 0; i < 32; i++)
            send_req(1'b0, (i < 16) ? addr_t'(i) : addr_t'(RAM_DEPTH + i - 16), '0);
        if (!test_skipped)
            drain();
        end_test("image and boot rom reads");

        start_test();
        grant_mode = GRANT_RANDOM;
        for (i = 0; i < N_RANDOM && !aborted; i++)
        begin
            r = next_random();
            a = pick_addr(r);
            if (r[11:10] == 2'b00)
                drive_cycle(1'b0, 1'b0, '0, '0); // idle gap
            send_req(r[8] || !known[a], a, word_t'(next_random())); // unknown word gets written
        end
        if (!test_skipped)
            drain();
        end_test("random reads and writes");

        start_test();
        if (!test_skipped)
        begin
            check_count(credit_pulses, sent_count, "request credit pulses");
            check_count(rsp_count, read_count, "responses for reads sent");
        end
        end_test("credit accounting");

        start_test();
        if (!test_skipped)
        begin
            grant_mode = GRANT_NONE;
            bank_start = rsp_bank;
            rsp_start  = rsp_count;
            for (i = 0; i < bank_start + 40; i++) // long enough to stall
            begin
                r = next_random();
                a = r[0] ? addr_t'(RAM_DEPTH + int'(r[7:4])) : addr_t'(r[7:4]);
                if (host_credits > 0)
                    drive_cycle(1'b1, 1'b0, a, '0);
                else
                    drive_cycle(1'b0, 1'b0, '0, '0);
            end
            check_count(rsp_count - rsp_start, bank_start, "responses on banked credits");
            check_count(host_credits, 0, "host credits with the pipeline stalled");
            grant_mode = GRANT_RANDOM;
            drain();
            check_count(credit_pulses, sent_count, "request credit pulses after stall");
        end
        end_test("response back-pressure");

        $display("tests %0d, checks %0d, errors %0d, requests %0d, responses %0d",
                 test_num, checks, errors, sent_count, rsp_count);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim.f
source/mem_pkg.sv
source/ram16.sv
source/boot_rom16.sv
source/bus_decode.sv
source/inst_mem.sv
source/rsp_return.sv
source/inst_mem_top.sv
dv/tb_inst_mem.sv

// File: Makefile
# Verilator flow for the instruction memory subsystem

TOP := tb_inst_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)
	verilator --lint-only --top-module inst_mem_top \
		source/mem_pkg.sv source/ram16.sv source/boot_rom16.sv \
		source/bus_decode.sv source/inst_mem.sv source/rsp_return.sv \
		source/inst_mem_top.sv

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: boot16.hex
// bootloader rom, one 16-bit hex word per line, window offsets 0 to 15
1a01
2b02
0010
00f0
3c03
4d04
0008
5e05
6f06
7a07
8b08
9c09
ad0a
be0b
cf0c
d00d
